/* alu.sv */
`timescale 1ns/1ps

module alu
(
    input  mips_pkg::word_t   i_a,
    input  mips_pkg::word_t   i_b,
    input  logic [4:0]        i_shamt,
    input  mips_pkg::alu_op_t i_op,
    output mips_pkg::word_t   o_result,
    output logic              o_zero
);

    import mips_pkg::*;

    word_t result;

    always_comb
    begin
        case (i_op)
            ALU_ADD:
                result = i_a + i_b;
            ALU_SUB:
                result = i_a - i_b;
            ALU_AND:
                result = i_a & i_b;
            ALU_OR:
                result = i_a | i_b;
            ALU_XOR:
                result = i_a ^ i_b;
            ALU_NOR:
                result = ~(i_a | i_b);
            ALU_SLT:
                result = word_t'($signed(i_a) < $signed(i_b));
            ALU_SLTU:
                result = word_t'(i_a < i_b);
            // Shifts operate on rt, as in MIPS
            ALU_SLL:
                result = i_b << i_shamt;
            ALU_SRL:
                result = i_b >> i_shamt;
            ALU_SRA:
                result = $signed(i_b) >>> i_shamt;
            ALU_LUI:
                result = {i_b[15:0], 16'h0000};
            default:
                result = '0;
        endcase
    end

    assign o_result = result;

    // Zero flag drives beq/bne after SUB
    assign o_zero = (result == '0);

endmodule

/* data_memory.sv */
`timescale 1ns/1ps

module data_memory
#(
    parameter int NBITS     = mips_pkg::NBITS,
    parameter int MEM_WORDS = 256
)
(
    input  logic               i_clk,
    input  mips_pkg::word_t    i_addr,
    input  mips_pkg::word_t    i_wdata,
    input  logic [NBITS/8-1:0] i_byte_en,
    input  logic               i_we,
    output mips_pkg::word_t    o_rdata
);

    localparam int LANES = NBITS / 8;
    localparam int AW    = $clog2(MEM_WORDS);

    logic [NBITS-1:0] mem [MEM_WORDS];
    logic [AW-1:0]    word_idx;

    // Word index, byte offset dropped and wrapped to depth
    assign word_idx = i_addr[AW+1:2];

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            for (int lane = 0; lane < LANES; lane++)
            begin
                if (i_byte_en[lane])
                begin
                    mem[word_idx][8*lane +: 8] <= i_wdata[8*lane +: 8];
                end
            end
        end
    end

    // Asynchronous read of the whole word
    assign o_rdata = mem[word_idx];

endmodule

/* ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg
#(
    parameter int NBITS = mips_pkg::NBITS,
    parameter int REGS  = mips_pkg::REGS
)
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_flush,
    input  logic [NBITS-1:0]      i_pc4,
    input  logic [NBITS-1:0]      i_pc8,
    input  logic [NBITS-1:0]      i_pc_branch,
    input  logic [NBITS-1:0]      i_instruction,
    input  logic                  i_zero,
    input  logic [NBITS-1:0]      i_alu,
    input  logic [NBITS-1:0]      i_rt_data,
    input  logic [REGS-1:0]       i_reg_dest,
    input  logic [NBITS-1:0]      i_extension,
    input  logic                  i_branch,
    input  logic                  i_nbranch,
    input  logic                  i_mem_write,
    input  logic                  i_mem_read,
    input  mips_pkg::size_t       i_store_size,
    input  logic                  i_jal,
    input  logic                  i_mem_to_reg,
    input  logic                  i_reg_write,
    input  mips_pkg::size_t       i_load_size,
    input  logic                  i_zero_extend,
    input  logic                  i_lui,
    output logic [NBITS-1:0]      o_pc4,
    output logic [NBITS-1:0]      o_pc8,
    output logic [NBITS-1:0]      o_pc_branch,
    output logic [NBITS-1:0]      o_instruction,
    output logic                  o_zero,
    output logic [NBITS-1:0]      o_alu,
    output logic [NBITS-1:0]      o_rt_data,
    output logic [REGS-1:0]       o_reg_dest,
    output logic [NBITS-1:0]      o_extension,
    output logic                  o_branch,
    output logic                  o_nbranch,
    output logic                  o_mem_write,
    output logic                  o_mem_read,
    output mips_pkg::size_t       o_store_size,
    output logic                  o_jal,
    output logic                  o_mem_to_reg,
    output logic                  o_reg_write,
    output mips_pkg::size_t       o_load_size,
    output logic                  o_zero_extend,
    output logic                  o_lui
);

    // Side-effect bits, squashed on reset or flush
    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            o_branch    <= 1'b0;
            o_nbranch   <= 1'b0;
            o_mem_write <= 1'b0;
            o_mem_read  <= 1'b0;
            o_jal       <= 1'b0;
            o_reg_write <= 1'b0;
        end
        else
        begin
            o_branch    <= i_branch;
            o_nbranch   <= i_nbranch;
            o_mem_write <= i_mem_write;
            o_mem_read  <= i_mem_read;
            o_jal       <= i_jal;
            o_reg_write <= i_reg_write;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_pc4         <= i_pc4;
        o_pc8         <= i_pc8;
        o_pc_branch   <= i_pc_branch;
        o_instruction <= i_instruction;
        o_zero        <= i_zero;
        o_alu         <= i_alu;
        o_rt_data     <= i_rt_data;
        o_reg_dest    <= i_reg_dest;
        o_extension   <= i_extension;
        o_store_size  <= i_store_size;
        o_mem_to_reg  <= i_mem_to_reg;
        o_load_size   <= i_load_size;
        o_zero_extend <= i_zero_extend;
        o_lui         <= i_lui;
    end

endmodule

/* ex_mem_top.sv */
`timescale 1ns/1ps

module ex_mem_top
#(
    parameter int NBITS     = mips_pkg::NBITS,
    parameter int MEM_WORDS = 256
)
(
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_flush,
    input  mips_pkg::word_t    i_pc4,
    input  mips_pkg::word_t    i_instruction,
    input  mips_pkg::word_t    i_rs_data,
    input  mips_pkg::word_t    i_rt_data,
    input  mips_pkg::word_t    i_extension,
    input  logic               i_alu_src,
    input  mips_pkg::alu_op_t  i_alu_op,
    input  logic               i_reg_dst,
    input  logic               i_branch,
    input  logic               i_nbranch,
    input  logic               i_mem_write,
    input  logic               i_mem_read,
    input  mips_pkg::size_t    i_store_size,
    input  logic               i_jal,
    input  logic               i_mem_to_reg,
    input  logic               i_reg_write,
    input  mips_pkg::size_t    i_load_size,
    input  logic               i_zero_extend,
    input  logic               i_lui,
    output logic               o_pc_src,
    output mips_pkg::word_t    o_pc_branch,
    output mips_pkg::word_t    o_alu,
    output mips_pkg::word_t    o_load_data,
    output mips_pkg::word_t    o_rt_data,
    output mips_pkg::reg_idx_t o_reg_dest,
    output mips_pkg::word_t    o_pc8,
    output mips_pkg::word_t    o_extension,
    output logic               o_reg_write,
    output logic               o_mem_to_reg,
    output logic               o_jal,
    output logic               o_lui
);

    import mips_pkg::*;

    // Execute results
    word_t    ex_alu;
    logic     ex_zero;
    word_t    ex_pc_branch;
    word_t    ex_pc8;
    reg_idx_t ex_reg_dest;

    // Registered M controls
    logic     mem_zero;
    logic     mem_branch;
    logic     mem_nbranch;
    logic     mem_mem_write;
    size_t    mem_store_size;
    size_t    mem_load_size;
    logic     mem_zero_extend;

    execute_stage #(
        .NBITS (NBITS)
    ) u_execute_stage (
        .i_pc4         (i_pc4),
        .i_instruction (i_instruction),
        .i_rs_data     (i_rs_data),
        .i_rt_data     (i_rt_data),
        .i_extension   (i_extension),
        .i_alu_src     (i_alu_src),
        .i_reg_dst     (i_reg_dst),
        .i_jal         (i_jal),
        .i_alu_op      (i_alu_op),
        .o_alu         (ex_alu),
        .o_zero        (ex_zero),
        .o_pc_branch   (ex_pc_branch),
        .o_pc8         (ex_pc8),
        .o_reg_dest    (ex_reg_dest)
    );

    // Registered pc4, instruction and mem_read have no consumer here
    ex_mem_reg #(
        .NBITS (NBITS),
        .REGS  (REGS)
    ) u_ex_mem_reg (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_flush       (i_flush),
        .i_pc4         (i_pc4),
        .i_pc8         (ex_pc8),
        .i_pc_branch   (ex_pc_branch),
        .i_instruction (i_instruction),
        .i_zero        (ex_zero),
        .i_alu         (ex_alu),
        .i_rt_data     (i_rt_data),
        .i_reg_dest    (ex_reg_dest),
        .i_extension   (i_extension),
        .i_branch      (i_branch),
        .i_nbranch     (i_nbranch),
        .i_mem_write   (i_mem_write),
        .i_mem_read    (i_mem_read),
        .i_store_size  (i_store_size),
        .i_jal         (i_jal),
        .i_mem_to_reg  (i_mem_to_reg),
        .i_reg_write   (i_reg_write),
        .i_load_size   (i_load_size),
        .i_zero_extend (i_zero_extend),
        .i_lui         (i_lui),
        .o_pc4         (),
        .o_pc8         (o_pc8),
        .o_pc_branch   (o_pc_branch),
        .o_instruction (),
        .o_zero        (mem_zero),
        .o_alu         (o_alu),
        .o_rt_data     (o_rt_data),
        .o_reg_dest    (o_reg_dest),
        .o_extension   (o_extension),
        .o_branch      (mem_branch),
        .o_nbranch     (mem_nbranch),
        .o_mem_write   (mem_mem_write),
        .o_mem_read    (),
        .o_store_size  (mem_store_size),
        .o_jal         (o_jal),
        .o_mem_to_reg  (o_mem_to_reg),
        .o_reg_write   (o_reg_write),
        .o_load_size   (mem_load_size),
        .o_zero_extend (mem_zero_extend),
        .o_lui         (o_lui)
    );

    memory_stage #(
        .NBITS     (NBITS),
        .MEM_WORDS (MEM_WORDS)
    ) u_memory_stage (
        .i_clk         (i_clk),
        .i_alu         (o_alu),
        .i_rt_data     (o_rt_data),
        .i_zero        (mem_zero),
        .i_branch      (mem_branch),
        .i_nbranch     (mem_nbranch),
        .i_mem_write   (mem_mem_write),
        .i_store_size  (mem_store_size),
        .i_load_size   (mem_load_size),
        .i_zero_extend (mem_zero_extend),
        .o_pc_src      (o_pc_src),
        .o_load_data   (o_load_data)
    );

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
#(
    parameter int NBITS = mips_pkg::NBITS
)
(
    input  mips_pkg::word_t    i_pc4,
    input  mips_pkg::word_t    i_instruction,
    input  mips_pkg::word_t    i_rs_data,
    input  mips_pkg::word_t    i_rt_data,
    input  mips_pkg::word_t    i_extension,
    input  logic               i_alu_src,
    input  logic               i_reg_dst,
    input  logic               i_jal,
    input  mips_pkg::alu_op_t  i_alu_op,
    output mips_pkg::word_t    o_alu,
    output logic               o_zero,
    output mips_pkg::word_t    o_pc_branch,
    output mips_pkg::word_t    o_pc8,
    output mips_pkg::reg_idx_t o_reg_dest
);

    import mips_pkg::*;

    word_t            alu_b;
    logic [4:0]       shamt;
    logic [NBITS-1:0] branch_offset;
    reg_idx_t         rt_field;
    reg_idx_t         rd_field;

    // Immediate or register as second operand
    assign alu_b = i_alu_src ? i_extension : i_rt_data;

    assign shamt = i_instruction[10:6];

    alu u_alu
    (
        .i_a      (i_rs_data),
        .i_b      (alu_b),
        .i_shamt  (shamt),
        .i_op     (i_alu_op),
        .o_result (o_alu),
        .o_zero   (o_zero)
    );

    // Word offset to byte offset
    assign branch_offset = {i_extension[NBITS-3:0], 2'b00};

    assign o_pc_branch = i_pc4 + branch_offset;

    // Return address for jal
    assign o_pc8 = i_pc4 + 32'd4;

    assign rt_field = i_instruction[20:16];
    assign rd_field = i_instruction[15:11];

    always_comb
    begin
        if (i_jal)
        begin
            o_reg_dest = RA_REG;
        end
        else if (i_reg_dst)
        begin
            o_reg_dest = rd_field;
        end
        else
        begin
            o_reg_dest = rt_field;
        end
    end

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage
#(
    parameter int NBITS     = mips_pkg::NBITS,
    parameter int MEM_WORDS = 256
)
(
    input  logic            i_clk,
    input  mips_pkg::word_t i_alu,
    input  mips_pkg::word_t i_rt_data,
    input  logic            i_zero,
    input  logic            i_branch,
    input  logic            i_nbranch,
    input  logic            i_mem_write,
    input  mips_pkg::size_t i_store_size,
    input  mips_pkg::size_t i_load_size,
    input  logic            i_zero_extend,
    output logic            o_pc_src,
    output mips_pkg::word_t o_load_data
);

    import mips_pkg::*;

    logic [NBITS/8-1:0] byte_en;
    word_t              wdata;
    word_t              rdata;
    logic [7:0]         load_byte;
    logic [15:0]        load_half;

    // beq on zero, bne on nonzero
    assign o_pc_src = (i_branch && i_zero) || (i_nbranch && !i_zero);

    // Replicate store data across lanes, then pick lanes by address
    always_comb
    begin
        case (i_store_size)
            SIZE_BYTE:
            begin
                wdata   = {4{i_rt_data[7:0]}};
                byte_en = 4'b0001 << i_alu[1:0];
            end
            SIZE_HALF:
            begin
                wdata   = {2{i_rt_data[15:0]}};
                byte_en = i_alu[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                wdata   = i_rt_data;
                byte_en = 4'b1111;
            end
        endcase
    end

    data_memory #(
        .NBITS     (NBITS),
        .MEM_WORDS (MEM_WORDS)
    ) u_data_memory (
        .i_clk     (i_clk),
        .i_addr    (i_alu),
        .i_wdata   (wdata),
        .i_byte_en (byte_en),
        .i_we      (i_mem_write),
        .o_rdata   (rdata)
    );

    assign load_byte = rdata[8*i_alu[1:0] +: 8];
    assign load_half = i_alu[1] ? rdata[31:16] : rdata[15:0];

    always_comb
    begin
        case (i_load_size)
            SIZE_BYTE:
                o_load_data = {{(NBITS-8){load_byte[7] & ~i_zero_extend}}, load_byte};
            SIZE_HALF:
                o_load_data = {{(NBITS-16){load_half[15] & ~i_zero_extend}}, load_half};
            default:
                o_load_data = rdata;
        endcase
    end

endmodule

/* mips_pkg.sv */
package mips_pkg;

    // Datapath and register index widths
    localparam int NBITS = 32;
    localparam int REGS  = 5;

    typedef logic [NBITS-1:0] word_t;
    typedef logic [REGS-1:0]  reg_idx_t;

    // Link register written by jal
    localparam reg_idx_t RA_REG = 5'd31;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    // Access size, same code for loads and stores
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

endpackage

/* sources.f */
mips_pkg.sv
alu.sv
execute_stage.sv
ex_mem_reg.sv
data_memory.sv
memory_stage.sv
ex_mem_top.sv
tb_ex_mem_top.sv

/* tb_ex_mem_top.sv */
`timescale 1ns/1ps

module tb_ex_mem_top;

    import mips_pkg::*;

    localparam int MEM_WORDS = 256;

    logic     i_clk, i_rst, i_flush;
    word_t    i_pc4, i_instruction, i_rs_data, i_rt_data, i_extension;
    logic     i_alu_src, i_reg_dst, i_branch, i_nbranch, i_mem_write, i_mem_read;
    alu_op_t  i_alu_op;
    size_t    i_store_size, i_load_size;
    logic     i_jal, i_mem_to_reg, i_reg_write, i_zero_extend, i_lui;
    logic     o_pc_src, o_reg_write, o_mem_to_reg, o_jal, o_lui;
    word_t    o_pc_branch, o_alu, o_load_data, o_rt_data, o_pc8, o_extension;
    reg_idx_t o_reg_dest;

    // Expected outputs of the instruction now in the EX/MEM register
    logic     exp_valid, exp_load_valid;
    word_t    exp_alu, exp_pc_branch, exp_pc8, exp_rt_data, exp_extension, exp_load;
    reg_idx_t exp_reg_dest;
    logic     exp_pc_src, exp_reg_write, exp_mem_to_reg, exp_jal, exp_lui;

    logic        load_check;
    word_t       shadow [MEM_WORDS];
    int          edge_count = 0;
    realtime     edge_time;
    logic [31:0] seed;
    word_t       addr;

    ex_mem_top uut (.*);

    initial
    begin
        i_clk = 1'b0;
        edge_time = 0.0;
        forever
        begin
            #5 i_clk = 1'b1;
            edge_count++;
            edge_time = $realtime;
            #5 i_clk = 1'b0;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift32(seed);
        return seed;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected)
        else
            stop_with_failure($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
                                        name, expected, actual));
    endtask

    // Advance to 1 ns after the next rising edge
    task automatic next_cycle();
        int start;
        int polls;
        start = edge_count;
        polls = 0;
        while (edge_count == start)
        begin
            #1;
            polls++;
            if (polls > 20)
                stop_with_failure("Timeout: the clock gave no rising edge within 20 ns");
        end
        // Settle relative to the recorded edge time
        #(edge_time + 1.0 - $realtime);
    endtask

    function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b,
                                        input logic [4:0] sh);
        logic [63:0] wide;
        word_t       r;
        wide = {{32{b[31]}}, b} >> sh;
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_NOR:  r = ~(a | b);
            // Differing signs decide directly, else unsigned order holds
            ALU_SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            ALU_SLTU: r = {31'b0, a < b};
            ALU_SLL:  r = b << sh;
            ALU_SRL:  r = b >> sh;
            ALU_SRA:  r = wide[31:0];
            ALU_LUI:  r = {b[15:0], 16'h0000};
            default:  r = '0;
        endcase
        return r;
    endfunction

    function automatic word_t model_load(input word_t w, input logic [1:0] lane,
                                         input size_t size, input logic zext);
        word_t       shifted;
        logic [15:0] h;
        shifted = w >> (8 * lane);
        h = lane[1] ? w[31:16] : w[15:0];
        if (size == SIZE_BYTE)
            return (zext || !shifted[7]) ? {24'h0, shifted[7:0]} : {24'hffffff, shifted[7:0]};
        else if (size == SIZE_HALF)
            return (zext || !h[15]) ? {16'h0, h} : {16'hffff, h};
        else
            return w;
    endfunction

    task automatic apply_store(input word_t a, input word_t data, input size_t size);
        int idx;
        idx = (a >> 2) % MEM_WORDS;
        case (size)
            SIZE_BYTE: shadow[idx][8*a[1:0] +: 8] = data[7:0];
            SIZE_HALF: shadow[idx][16*a[1] +: 16] = data[15:0];
            default:   shadow[idx] = data;
        endcase
    endtask

    task automatic check_outputs();
        check_word("o_alu", exp_alu, o_alu);
        check_word("o_pc_branch", exp_pc_branch, o_pc_branch);
        check_word("o_pc8", exp_pc8, o_pc8);
        check_word("o_reg_dest", {27'b0, exp_reg_dest}, {27'b0, o_reg_dest});
        check_word("o_rt_data", exp_rt_data, o_rt_data);
        check_word("o_extension", exp_extension, o_extension);
        check_word("o_pc_src", {31'b0, exp_pc_src}, {31'b0, o_pc_src});
        check_word("o_reg_write", {31'b0, exp_reg_write}, {31'b0, o_reg_write});
        check_word("o_mem_to_reg", {31'b0, exp_mem_to_reg}, {31'b0, o_mem_to_reg});
        check_word("o_jal", {31'b0, exp_jal}, {31'b0, o_jal});
        check_word("o_lui", {31'b0, exp_lui}, {31'b0, o_lui});
        if (exp_load_valid)
            check_word("o_load_data", exp_load, o_load_data);
    endtask

    // Check the previous item, predict the one just driven, then clock it in
    task automatic step();
        word_t res;
        logic  squash;
        if (exp_valid)
            check_outputs();
        res = model_alu(i_alu_op, i_rs_data, i_alu_src ? i_extension : i_rt_data,
                        i_instruction[10:6]);
        squash = i_rst || i_flush;
        exp_alu = res;
        exp_pc_branch = i_pc4 + (i_extension << 2);
        exp_pc8 = i_pc4 + 32'd4;
        exp_reg_dest = i_jal ? RA_REG : (i_reg_dst ? i_instruction[15:11] : i_instruction[20:16]);
        exp_rt_data = i_rt_data;
        exp_extension = i_extension;
        exp_pc_src = !squash && ((i_branch && res == 0) || (i_nbranch && res != 0));
        exp_reg_write = !squash && i_reg_write;
        exp_jal = !squash && i_jal;
        exp_mem_to_reg = i_mem_to_reg;
        exp_lui = i_lui;
        exp_load_valid = load_check;
        if (load_check)
            exp_load = model_load(shadow[(res >> 2) % MEM_WORDS], res[1:0], i_load_size,
                                  i_zero_extend);
        // Memory takes the store one edge after this item is registered
        if (!squash && i_mem_write)
            apply_store(res, i_rt_data, i_store_size);
        exp_valid = 1'b1;
        next_cycle();
    endtask

    task automatic clear_inputs();
        i_flush = 1'b0;
        {i_pc4, i_instruction, i_rs_data, i_rt_data, i_extension} = '0;
        {i_alu_src, i_reg_dst, i_branch, i_nbranch, i_mem_write, i_mem_read} = '0;
        {i_jal, i_mem_to_reg, i_reg_write, i_zero_extend, i_lui} = '0;
        i_alu_op = ALU_ADD;
        i_store_size = SIZE_WORD;
        i_load_size = SIZE_WORD;
        load_check = 1'b0;
    endtask

    task automatic random_item();
        logic [31:0] bits;
        clear_inputs();
        bits = next_rand();
        i_pc4 = next_rand();
        i_instruction = next_rand();
        i_rs_data = next_rand();
        i_rt_data = next_rand();
        i_extension = next_rand();
        {i_reg_dst, i_branch, i_nbranch, i_jal, i_reg_write, i_mem_to_reg, i_lui} = bits[6:0];
    endtask

    // Base plus small offset through ALU add
    task automatic set_address(input word_t a);
        word_t off;
        off = next_rand() & 32'hf;
        i_alu_op = ALU_ADD;
        i_alu_src = 1'b1;
        i_rs_data = a - off;
        i_extension = off;
    endtask

    initial
    begin
        seed = 32'hb487d313;
        exp_valid = 1'b0;
        i_rst = 1'b1;
        clear_inputs();
        for (int n = 0; n < 4; n++)
        begin
            random_item();
            {i_branch, i_nbranch, i_jal, i_reg_write} = 4'b1111;
            step();
        end
        i_rst = 1'b0;

        // Word stores fill the test region
        for (int w = 0; w < 16; w++)
        begin
            clear_inputs();
            set_address(4 * w);
            i_mem_write = 1'b1;
            i_rt_data = next_rand();
            step();
        end

        for (int op = 0; op < 12; op++)
            for (int src = 0; src < 2; src++)
                for (int k = 0; k < 4; k++)
                begin
                    random_item();
                    i_alu_op = alu_op_t'(op);
                    i_alu_src = src[0];
                    step();
                end

        // beq and bne with equal and unequal operands
        for (int k = 0; k < 8; k++)
        begin
            random_item();
            i_alu_op = ALU_SUB;
            if (k[0])
                i_rt_data = i_rs_data;
            i_branch = k[1];
            i_nbranch = k[2];
            step();
        end

        for (int n = 0; n < 48; n++)
        begin
            addr = next_rand() & 32'h3f;
            clear_inputs();
            set_address(addr);
            i_mem_write = 1'b1;
            i_store_size = size_t'(n % 3);
            i_rt_data = next_rand();
            step();
            clear_inputs();
            set_address(addr);
            i_mem_read = 1'b1;
            i_load_size = size_t'((n / 3) % 3);
            i_zero_extend = ((n / 9) % 2) != 0;
            load_check = 1'b1;
            step();
        end

        // Flushed store and register write
        for (int n = 0; n < 4; n++)
        begin
            addr = next_rand() & 32'h3f;
            clear_inputs();
            set_address(addr);
            i_flush = 1'b1;
            i_mem_write = 1'b1;
            i_reg_write = 1'b1;
            i_rt_data = next_rand();
            step();
            clear_inputs();
            set_address(addr & ~32'h3);
            load_check = 1'b1;
            step();
        end

        clear_inputs();
        step();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
